//--- Makefile
TOP := tb_bnn_classifier

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+include
source/bnn_pkg.sv
source/bnn_hidden_layer.sv
source/bnn_output_scorer.sv
source/argmax.sv
source/bnn_classifier.sv
dv/bnn_checker.sv
dv/tb_bnn_classifier.sv

//--- dv/bnn_checker.sv
`timescale 1ns/1ps

`include "bnn_macros.svh"

module bnn_checker (
    input logic                clk,
    input logic                reset,
    input logic                out_valid,
    input bnn_pkg::class_idx_t prediction
);

    // Expected class and entry cycle per sample in flight.
    bnn_pkg::class_idx_t exp_q[$];
    int                  entry_q[$];

    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int out_count   = 0;

    function automatic void push_expected(input bnn_pkg::class_idx_t cls);
        exp_q.push_back(cls);
        entry_q.push_back(cycle_count);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic compare_output();
        bnn_pkg::class_idx_t exp_class;
        int                  entry;
        out_count++;
        if (exp_q.size() == 0) begin
            $display("Output at time %0t with no sample in flight", $time);
            error_count++;
        end else begin
            exp_class = exp_q.pop_front();
            entry     = entry_q.pop_front();
            check_count++;
            if (prediction !== exp_class) begin
                $display("[ERROR] %0t prediction expected %0d actual %0d",
                         $time, exp_class, prediction);
                error_count++;
            end
            // Latency counted in clock edges from the drive.
            check_count++;
            if (cycle_count - entry != `BNN_LATENCY) begin
                $display("Output at time %0t came %0d cycles after its input, not %0d",
                         $time, cycle_count - entry, `BNN_LATENCY);
                error_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset && out_valid) begin
            compare_output();
        end
    end

endmodule

//--- dv/bnn_trace.txt
# gap_cycles features_hex(feature 0 in low nibble) expected_class
# Zero vector, single-feature extremes on features 0 and 10, back-to-back bursts.
3 00000000000 2
5 0000000000f 0
4 f0000000000 2
0 00000000001 0
0 10000000000 2
0 00000000000 2
0 00000000008 0
2 80000000000 2
0 0000000000f 0
0 0000000000f 0
0 00000000000 2
6 f0000000000 2
1 00000000001 0

//--- dv/tb_bnn_classifier.sv
`timescale 1ns/1ps

`include "bnn_macros.svh"

module tb_bnn_classifier;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    bnn_pkg::feature_vec_t features;
    logic                  out_valid;
    bnn_pkg::class_idx_t   prediction;

    int                    gaps[$];
    bnn_pkg::feature_vec_t feats[$];
    bnn_pkg::class_idx_t   classes[$];

    int cycle_count = 0;
    int cycle_limit = 0;
    int tb_errors   = 0;
    int total_errors;

    bnn_classifier i_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .features   (features),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

    bnn_checker i_checker (
        .clk        (clk),
        .reset      (reset),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic read_trace();
        int                    fd;
        int                    n;
        int                    gap;
        int                    cls;
        int                    max_gap;
        string                 line;
        bnn_pkg::feature_vec_t feat;
        max_gap = 0;
        fd = $fopen("dv/bnn_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file dv/bnn_trace.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%d %h %d", gap, feat, cls);
                    if (n == 3) begin
                        gaps.push_back(gap);
                        feats.push_back(feat);
                        classes.push_back(bnn_pkg::class_idx_t'(cls));
                        if (gap > max_gap) begin
                            max_gap = gap;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = gaps.size() * (max_gap + 1) + `BNN_LATENCY + 20;
    endtask

    // Called 1 ns after a rising edge; returns at the same offset.
    task automatic drive_samples();
        for (int i = 0; i < gaps.size(); i++) begin
            repeat (gaps[i]) begin
                in_valid = 1'b0;
                features = '0;
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            features = feats[i];
            i_checker.push_expected(classes[i]);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        features = '0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with outputs still missing", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        features = '0;
        read_trace();
        if (classes.size() == 0) begin
            $display("The trace holds no samples");
            tb_errors++;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_samples();
        while (i_checker.pending() != 0) begin
            @(posedge clk);
        end
        // Extra cycles to catch stray outputs.
        repeat (`BNN_LATENCY + 2) @(posedge clk);
        if (i_checker.out_count != classes.size()) begin
            $display("Saw %0d outputs for %0d trace samples",
                     i_checker.out_count, classes.size());
            tb_errors++;
        end
        total_errors = i_checker.error_count + tb_errors;
        $display("Checks: %0d, errors: %0d", i_checker.check_count, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- include/bnn_macros.svh
`ifndef BNN_MACROS_SVH
`define BNN_MACROS_SVH

// Network dimensions.
`define BNN_FEAT_CNT    11
`define BNN_FEAT_BITS   4
`define BNN_HIDDEN_CNT  40
`define BNN_CLASS_CNT   7

// Register stages from features to prediction.
`define BNN_LATENCY     3

// First layer masks, eleven bits per neuron, neuron 0 lowest.
`define BNN_W1_POS {40'h9a3c51e807, 40'h4d2b86f013, 40'hc570a93e28, 40'h1f86d24b90, \
    40'he30958ac71, 40'h62da0f1c84, 40'hb8417e2935, 40'h0c9fa56d12, 40'h7e2318b4c6, \
    40'ha5c06d3f98, 40'h3b718e0c45}

`define BNN_W1_NEG {40'h2082aa02a8, 40'ha280280aa8, 40'h2a8a028082, 40'ha02828a02a, \
    40'h08a2a2028a, 40'h8820a0a22a, 40'h02aa80828a, 40'ha2200a82a8, 40'h8088a20a28, \
    40'h0a2a828022, 40'h808a20a2aa}

// Set bit means the neuron fires on a non-negative sum.
`define BNN_W1_POLARITY 40'hb6d3a58ec1

// Class weight rows, class 6 first in the list, class 0 in the low bits.
`define BNN_W2 {40'hc3a59e176b, 40'h5e0db238f4, 40'h91f64ca07d, 40'h2b8ed53c09, \
    40'he6470f9ab2, 40'h7d19a6e458, 40'ha0c27b5de3}

`endif

//--- source/argmax.sv
`timescale 1ns/1ps

`include "bnn_macros.svh"

module argmax (
    input  logic                  clk,
    input  logic                  reset,
    input  bnn_pkg::score_stage_t stage_in,
    output logic                  out_valid,
    output bnn_pkg::class_idx_t   prediction
);

    localparam int score_bits = $bits(bnn_pkg::class_score_t);

    bnn_pkg::class_score_t best_score;
    bnn_pkg::class_idx_t   best_idx;

    // Scan upward; strict compare keeps the lowest index on a tie.
    always_comb begin
        best_score = stage_in.scores[0 +: score_bits];
        best_idx   = '0;
        for (int c = 1; c < `BNN_CLASS_CNT; c++) begin
            if (stage_in.scores[c*score_bits +: score_bits] > best_score) begin
                best_score = stage_in.scores[c*score_bits +: score_bits];
                best_idx   = bnn_pkg::class_idx_t'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            prediction <= '0;
        end else begin
            out_valid <= stage_in.valid;
            if (stage_in.valid) begin
                prediction <= best_idx;
            end
        end
    end

    // Index must name a real class.
    a_pred_range: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> (prediction < `BNN_CLASS_CNT)
    ) else $error("prediction %0d out of class range", prediction);

endmodule

//--- source/bnn_classifier.sv
`timescale 1ns/1ps

`include "bnn_macros.svh"

module bnn_classifier (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  bnn_pkg::feature_vec_t features,
    output logic                  out_valid,
    output bnn_pkg::class_idx_t   prediction
);

    // Stage records between the pipeline registers.
    bnn_pkg::hidden_stage_t hidden_stage;
    bnn_pkg::score_stage_t  score_stage;

    // Stage 1. Masked sums and sign.
    bnn_hidden_layer i_hidden_layer (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .features  (features),
        .stage_out (hidden_stage)
    );

    // Stage 2. XNOR popcount per class.
    bnn_output_scorer i_output_scorer (
        .clk       (clk),
        .reset     (reset),
        .stage_in  (hidden_stage),
        .stage_out (score_stage)
    );

    // Stage 3. Pick the winner.
    argmax i_argmax (
        .clk        (clk),
        .reset      (reset),
        .stage_in   (score_stage),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

endmodule

//--- source/bnn_hidden_layer.sv
`timescale 1ns/1ps

`include "bnn_macros.svh"

module bnn_hidden_layer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  bnn_pkg::feature_vec_t  features,
    output bnn_pkg::hidden_stage_t stage_out
);

    localparam int mask_bits = `BNN_HIDDEN_CNT * `BNN_FEAT_CNT;

    localparam logic [mask_bits-1:0]       w1_pos      = `BNN_W1_POS;
    localparam logic [mask_bits-1:0]       w1_neg      = `BNN_W1_NEG;
    localparam logic [`BNN_HIDDEN_CNT-1:0] w1_polarity = `BNN_W1_POLARITY;

    bnn_pkg::hidden_vec_t hidden_next;

    // Zero-extend one feature to the signed sum width.
    function automatic bnn_pkg::node_sum_t extend_feature(
        input bnn_pkg::feature_vec_t vec,
        input int                    idx
    );
        bnn_pkg::feature_t feat;
        feat = vec[idx*`BNN_FEAT_BITS +: `BNN_FEAT_BITS];
        return bnn_pkg::node_sum_t'({1'b0, feat});
    endfunction

    for (genvar n = 0; n < `BNN_HIDDEN_CNT; n++) begin : g_neuron
        localparam logic [`BNN_FEAT_CNT-1:0] pos_mask =
            w1_pos[n*`BNN_FEAT_CNT +: `BNN_FEAT_CNT];
        localparam logic [`BNN_FEAT_CNT-1:0] neg_mask =
            w1_neg[n*`BNN_FEAT_CNT +: `BNN_FEAT_CNT];
        localparam logic polarity = w1_polarity[n];

        bnn_pkg::node_sum_t node_sum;

        // Masked sum of the features.
        always_comb begin
            node_sum = '0;
            for (int f = 0; f < `BNN_FEAT_CNT; f++) begin
                if (pos_mask[f]) begin
                    node_sum = node_sum + extend_feature(features, f);
                end
                if (neg_mask[f]) begin
                    node_sum = node_sum - extend_feature(features, f);
                end
            end
        end

        // Sign threshold, direction chosen per neuron.
        always_comb begin
            if (polarity) begin
                hidden_next[n] = (node_sum >= 0);
            end else begin
                hidden_next[n] = (node_sum < 0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_out <= '0;
        end else begin
            stage_out.valid <= in_valid;
            // Hold the last vector between samples.
            if (in_valid) begin
                stage_out.hidden <= hidden_next;
            end
        end
    end

    // Valid trails the input strobe by exactly one cycle.
    a_valid_delay: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> (stage_out.valid == $past(in_valid))
    ) else $error("hidden stage valid is not in_valid delayed by one cycle");

endmodule

//--- source/bnn_output_scorer.sv
`timescale 1ns/1ps

`include "bnn_macros.svh"

module bnn_output_scorer (
    input  logic                   clk,
    input  logic                   reset,
    input  bnn_pkg::hidden_stage_t stage_in,
    output bnn_pkg::score_stage_t  stage_out
);

    localparam int score_bits = $bits(bnn_pkg::class_score_t);

    localparam logic [`BNN_CLASS_CNT*`BNN_HIDDEN_CNT-1:0] w2 = `BNN_W2;

    bnn_pkg::score_vec_t scores_next;

    for (genvar c = 0; c < `BNN_CLASS_CNT; c++) begin : g_class
        localparam logic [`BNN_HIDDEN_CNT-1:0] weight_row =
            w2[c*`BNN_HIDDEN_CNT +: `BNN_HIDDEN_CNT];

        bnn_pkg::hidden_vec_t  agree;
        bnn_pkg::class_score_t count;

        // XNOR marks positions where hidden bit and weight match.
        assign agree = ~(stage_in.hidden ^ weight_row);

        always_comb begin
            count = '0;
            for (int h = 0; h < `BNN_HIDDEN_CNT; h++) begin
                count = count + bnn_pkg::class_score_t'(agree[h]);
            end
        end

        assign scores_next[c*score_bits +: score_bits] = count;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_out <= '0;
        end else begin
            stage_out.valid <= stage_in.valid;
            if (stage_in.valid) begin
                stage_out.scores <= scores_next;
            end
        end
    end

    // A score never exceeds the hidden width.
    for (genvar c = 0; c < `BNN_CLASS_CNT; c++) begin : g_score_check
        a_score_range: assert property (
            @(posedge clk) disable iff (reset)
            stage_out.valid |->
                (stage_out.scores[c*score_bits +: score_bits] <= `BNN_HIDDEN_CNT)
        ) else $error("class %0d score above hidden count", c);
    end

endmodule

//--- source/bnn_pkg.sv
`include "bnn_macros.svh"

package bnn_pkg;

    typedef logic [`BNN_FEAT_BITS-1:0] feature_t;

    // Feature 0 sits in the low nibble.
    typedef logic [`BNN_FEAT_CNT*`BNN_FEAT_BITS-1:0] feature_vec_t;

    // Holds +/- eleven times the largest feature value.
    typedef logic signed [$clog2(`BNN_FEAT_CNT*((1 << `BNN_FEAT_BITS)-1)+1):0] node_sum_t;

    typedef logic [`BNN_HIDDEN_CNT-1:0] hidden_vec_t;

    typedef logic [$clog2(`BNN_HIDDEN_CNT+1)-1:0] class_score_t;

    typedef logic [`BNN_CLASS_CNT*$bits(class_score_t)-1:0] score_vec_t;

    typedef logic [$clog2(`BNN_CLASS_CNT)-1:0] class_idx_t;

    typedef struct packed {
        logic        valid;
        hidden_vec_t hidden;
    } hidden_stage_t;

    typedef struct packed {
        logic       valid;
        score_vec_t scores;
    } score_stage_t;

endpackage
